/* Bender.yml */
package:
  name: led_matrix

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/led_matrix_pkg.sv
      - hw/uart_rx.sv
      - hw/control_module.sv
      - hw/framebuffer_ram.sv
      - hw/framebuffer_fetch.sv
      - hw/matrix_scan.sv
      - hw/pixel_split.sv
      - hw/led_matrix_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/tb_led_matrix.sv

/* flist.f */
+incdir+include
hw/led_matrix_pkg.sv
hw/uart_rx.sv
hw/control_module.sv
hw/framebuffer_ram.sv
hw/framebuffer_fetch.sv
hw/matrix_scan.sv
hw/pixel_split.sv
hw/led_matrix_top.sv
verification/tb_led_matrix.sv

/* hw/control_module.sv */
`timescale 1ns/1ps
`include "led_matrix_defines.svh"

module control_module (
    input  logic                        clk_in,
    input  logic                        arst_n,
    input  logic [7:0]                  rx_data,
    input  logic                        rx_valid,
    output led_matrix_pkg::byte_addr_t  ram_wr_addr,
    output logic [7:0]                  ram_wr_data,
    output logic                        ram_wr_en,
    output led_matrix_pkg::rgb_bits_t   rgb_enable,
    output led_matrix_pkg::plane_mask_t brightness_enable
);
    localparam int FRAME_BYTES = `PIXEL_WIDTH * `PIXEL_HEIGHT * `BYTES_PER_PIXEL;
    localparam led_matrix_pkg::byte_addr_t BYTE_LAST =
        led_matrix_pkg::byte_addr_t'(FRAME_BYTES - 1);

    typedef enum logic [1:0] {IDLE, FRAME, ARG_RGB, ARG_BRIGHT} state_t;

    state_t                     state;
    led_matrix_pkg::byte_addr_t byte_count;

    // frame bytes go straight to the write port
    assign ram_wr_en = rx_valid && (state == FRAME);
    assign ram_wr_addr = byte_count;
    assign ram_wr_data = rx_data;

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
            byte_count <= '0;
            rgb_enable <= '1;
            brightness_enable <= '1;
        end else if (rx_valid) begin
            case (state)
                IDLE: begin
                    byte_count <= '0;
                    case (rx_data)
                        `CMD_FRAME: state <= FRAME;
                        `CMD_RGB_ENABLE: state <= ARG_RGB;
                        `CMD_BRIGHTNESS: state <= ARG_BRIGHT;
                        default: state <= IDLE; // unknown byte ignored
                    endcase
                end
                FRAME: begin
                    byte_count <= byte_count + 1'b1;
                    if (byte_count == BYTE_LAST) state <= IDLE;
                end
                ARG_RGB: begin
                    rgb_enable <= rx_data[2:0];
                    state <= IDLE;
                end
                default: begin
                    brightness_enable <= rx_data[5:0];
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

/* hw/framebuffer_fetch.sv */
`timescale 1ns/1ps
`include "led_matrix_defines.svh"

module framebuffer_fetch (
    input  logic                       clk_in,
    input  logic                       arst_n,
    input  logic                       pixel_load_start,
    input  led_matrix_pkg::col_addr_t  column_address,
    input  led_matrix_pkg::row_addr_t  row_address,
    output led_matrix_pkg::word_addr_t ram_rd_addr,
    output logic                       ram_rd_en,
    input  led_matrix_pkg::rgb565_t    ram_rd_data,
    output led_matrix_pkg::rgb565_t    rgb565_top,
    output led_matrix_pkg::rgb565_t    rgb565_bottom
);
    localparam int STAGES = `FETCH_LATENCY - 1;
    localparam led_matrix_pkg::word_addr_t HALF_OFFSET =
        led_matrix_pkg::word_addr_t'(`PIXEL_HALFHEIGHT * `PIXEL_WIDTH);

    logic [STAGES-1:0]          stage; // stage[i] is i+1 cycles after the strobe
    led_matrix_pkg::word_addr_t top_addr;
    led_matrix_pkg::rgb565_t    top_word;
    led_matrix_pkg::rgb565_t    bottom_word;

    assign top_addr = led_matrix_pkg::word_addr_t'(
        int'(row_address) * `PIXEL_WIDTH + int'(column_address));

    // top read in the strobe cycle, bottom read one cycle later
    assign ram_rd_en = pixel_load_start | stage[0];
    assign ram_rd_addr = stage[0] ? top_addr + HALF_OFFSET : top_addr;

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            stage <= '0;
            rgb565_top <= '0;
            rgb565_bottom <= '0;
        end else begin
            stage <= {stage[STAGES-2:0], pixel_load_start};
            if (stage[STAGES-1]) begin
                rgb565_top <= top_word;
                rgb565_bottom <= bottom_word;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (stage[0]) top_word <= ram_rd_data;
        if (stage[1]) bottom_word <= ram_rd_data;
    end

endmodule

/* hw/framebuffer_ram.sv */
`timescale 1ns/1ps
`include "led_matrix_defines.svh"

module framebuffer_ram (
    input  logic                       clk_in,
    input  led_matrix_pkg::byte_addr_t wr_addr,
    input  logic [7:0]                 wr_data,
    input  logic                       wr_en,
    input  led_matrix_pkg::word_addr_t rd_addr,
    input  logic                       rd_en,
    output led_matrix_pkg::rgb565_t    rd_data
);
    localparam int WORDS = `PIXEL_WIDTH * `PIXEL_HEIGHT;

    logic [7:0] mem_hi [WORDS];
    logic [7:0] mem_lo [WORDS];

    led_matrix_pkg::word_addr_t wr_word;

    assign wr_word = wr_addr[$bits(wr_addr)-1:1];

    always_ff @(posedge clk_in) begin
        if (wr_en && !wr_addr[0]) mem_hi[wr_word] <= wr_data; // even byte is the high half
        if (wr_en && wr_addr[0]) mem_lo[wr_word] <= wr_data;
        if (rd_en) rd_data <= {mem_hi[rd_addr], mem_lo[rd_addr]};
    end

endmodule

/* hw/led_matrix_pkg.sv */
`include "led_matrix_defines.svh"

package led_matrix_pkg;

    // high byte goes over the wire first
    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565_t;

    // one bit per brightness plane
    typedef logic [5:0] plane_mask_t;

    // red bit 0, green bit 1, blue bit 2
    typedef logic [2:0] rgb_bits_t;

    typedef logic [$clog2(`PIXEL_WIDTH)-1:0] col_addr_t;
    typedef logic [$clog2(`PIXEL_HALFHEIGHT)-1:0] row_addr_t;

    typedef logic [$clog2(`PIXEL_WIDTH * `PIXEL_HEIGHT * `BYTES_PER_PIXEL)-1:0] byte_addr_t;
    typedef logic [$clog2(`PIXEL_WIDTH * `PIXEL_HEIGHT)-1:0] word_addr_t;

endpackage

/* hw/led_matrix_top.sv */
`timescale 1ns/1ps

module led_matrix_top (
    input  logic                      clk_in,
    input  logic                      arst_n,
    input  logic                      uart_rx,
    output logic                      rx_running,
    output led_matrix_pkg::rgb_bits_t rgb1, // top half
    output led_matrix_pkg::rgb_bits_t rgb2, // bottom half
    output led_matrix_pkg::row_addr_t row_address_active,
    output logic                      clk_pixel,
    output logic                      row_latch,
    output logic                      output_enable_n
);
    logic [7:0]                  rx_data;
    logic                        rx_valid;
    led_matrix_pkg::byte_addr_t  ram_wr_addr;
    logic [7:0]                  ram_wr_data;
    logic                        ram_wr_en;
    led_matrix_pkg::word_addr_t  ram_rd_addr;
    logic                        ram_rd_en;
    led_matrix_pkg::rgb565_t     ram_rd_data;
    led_matrix_pkg::rgb_bits_t   rgb_enable;
    led_matrix_pkg::plane_mask_t brightness_enable;
    led_matrix_pkg::plane_mask_t brightness_mask;
    led_matrix_pkg::plane_mask_t plane_select;
    led_matrix_pkg::col_addr_t   column_address;
    led_matrix_pkg::row_addr_t   row_address;
    logic                        pixel_load_start;
    led_matrix_pkg::rgb565_t     rgb565_top;
    led_matrix_pkg::rgb565_t     rgb565_bottom;

    assign plane_select = brightness_mask & brightness_enable; // disabled planes go dark

    uart_rx i_uart_rx (
        .clk_in     (clk_in),
        .arst_n     (arst_n),
        .rx         (uart_rx),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .rx_running (rx_running)
    );

    control_module i_control_module (
        .clk_in            (clk_in),
        .arst_n            (arst_n),
        .rx_data           (rx_data),
        .rx_valid          (rx_valid),
        .ram_wr_addr       (ram_wr_addr),
        .ram_wr_data       (ram_wr_data),
        .ram_wr_en         (ram_wr_en),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable)
    );

    framebuffer_ram i_framebuffer_ram (
        .clk_in  (clk_in),
        .wr_addr (ram_wr_addr),
        .wr_data (ram_wr_data),
        .wr_en   (ram_wr_en),
        .rd_addr (ram_rd_addr),
        .rd_en   (ram_rd_en),
        .rd_data (ram_rd_data)
    );

    framebuffer_fetch i_framebuffer_fetch (
        .clk_in           (clk_in),
        .arst_n           (arst_n),
        .pixel_load_start (pixel_load_start),
        .column_address   (column_address),
        .row_address      (row_address),
        .ram_rd_addr      (ram_rd_addr),
        .ram_rd_en        (ram_rd_en),
        .ram_rd_data      (ram_rd_data),
        .rgb565_top       (rgb565_top),
        .rgb565_bottom    (rgb565_bottom)
    );

    matrix_scan i_matrix_scan (
        .clk_in             (clk_in),
        .arst_n             (arst_n),
        .column_address     (column_address),
        .row_address        (row_address),
        .pixel_load_start   (pixel_load_start),
        .brightness_mask    (brightness_mask),
        .clk_pixel          (clk_pixel),
        .row_latch          (row_latch),
        .output_enable_n    (output_enable_n),
        .row_address_active (row_address_active)
    );

    pixel_split px_top (
        .pixel           (rgb565_top),
        .brightness_mask (plane_select),
        .rgb_enable      (rgb_enable),
        .rgb_output      (rgb1)
    );

    pixel_split px_bottom (
        .pixel           (rgb565_bottom),
        .brightness_mask (plane_select),
        .rgb_enable      (rgb_enable),
        .rgb_output      (rgb2)
    );

endmodule

/* hw/matrix_scan.sv */
`timescale 1ns/1ps
`include "led_matrix_defines.svh"

module matrix_scan (
    input  logic                        clk_in,
    input  logic                        arst_n,
    output led_matrix_pkg::col_addr_t   column_address,
    output led_matrix_pkg::row_addr_t   row_address,
    output logic                        pixel_load_start,
    output led_matrix_pkg::plane_mask_t brightness_mask,
    output logic                        clk_pixel,
    output logic                        row_latch,
    output logic                        output_enable_n,
    output led_matrix_pkg::row_addr_t   row_address_active
);
    localparam int PLANES = 6;
    localparam int TW = $clog2((`OE_UNIT << (PLANES - 1)) + 1);
    localparam led_matrix_pkg::col_addr_t COL_LAST =
        led_matrix_pkg::col_addr_t'(`PIXEL_WIDTH - 1);
    localparam led_matrix_pkg::row_addr_t ROW_LAST =
        led_matrix_pkg::row_addr_t'(`PIXEL_HALFHEIGHT - 1);

    typedef enum logic [2:0] {LOAD, FETCH_WAIT, CLK_LOW, CLK_HIGH, LATCH, DISPLAY} state_t;

    state_t        state;
    logic [2:0]    plane;
    logic [TW-1:0] timer; // shared by every timed state
    logic          timer_done;

    assign timer_done = (timer == '0);
    assign pixel_load_start = (state == LOAD);
    assign clk_pixel = (state == CLK_HIGH);
    assign row_latch = (state == LATCH);
    assign output_enable_n = (state != DISPLAY); // lit only while displaying
    assign brightness_mask = led_matrix_pkg::plane_mask_t'(1) << plane;

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            state <= LOAD;
            column_address <= '0;
            row_address <= '0;
            row_address_active <= '0;
            plane <= '0;
            timer <= '0;
        end else begin
            timer <= timer - 1'b1;
            case (state)
                LOAD: begin
                    timer <= TW'(`FETCH_LATENCY - 1);
                    state <= FETCH_WAIT;
                end
                FETCH_WAIT: begin
                    if (timer_done) begin
                        timer <= TW'(`PIXEL_CLK_HALF - 1);
                        state <= CLK_LOW;
                    end
                end
                CLK_LOW: begin
                    if (timer_done) begin
                        timer <= TW'(`PIXEL_CLK_HALF - 1);
                        state <= CLK_HIGH;
                    end
                end
                CLK_HIGH: begin
                    if (timer_done && column_address == COL_LAST) begin
                        row_address_active <= row_address; // panel is blanked here
                        state <= LATCH;
                    end else if (timer_done) begin
                        column_address <= column_address + 1'b1;
                        state <= LOAD;
                    end
                end
                LATCH: begin
                    timer <= (TW'(`OE_UNIT) << plane) - 1'b1;
                    state <= DISPLAY;
                end
                default: begin
                    if (timer_done) begin
                        column_address <= '0;
                        state <= LOAD;
                        if (plane == 3'(PLANES - 1)) begin
                            plane <= '0;
                            row_address <= (row_address == ROW_LAST) ? '0 : row_address + 1'b1;
                        end else begin
                            plane <= plane + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

endmodule

/* hw/pixel_split.sv */
`timescale 1ns/1ps

module pixel_split (
    input  led_matrix_pkg::rgb565_t     pixel,
    input  led_matrix_pkg::plane_mask_t brightness_mask,
    input  led_matrix_pkg::rgb_bits_t   rgb_enable,
    output led_matrix_pkg::rgb_bits_t   rgb_output
);
    logic [5:0] red6;
    logic [5:0] green6;
    logic [5:0] blue6;

    // 5-bit channels widened by repeating the msb
    assign red6 = {pixel.red, pixel.red[4]};
    assign green6 = pixel.green;
    assign blue6 = {pixel.blue, pixel.blue[4]};

    assign rgb_output[0] = (|(red6 & brightness_mask)) & rgb_enable[0];
    assign rgb_output[1] = (|(green6 & brightness_mask)) & rgb_enable[1];
    assign rgb_output[2] = (|(blue6 & brightness_mask)) & rgb_enable[2];

endmodule

/* hw/uart_rx.sv */
`timescale 1ns/1ps
`include "led_matrix_defines.svh"

module uart_rx #(
    parameter int TICKS_PER_BIT = `UART_TICKS_PER_BIT
) (
    input  logic       clk_in,
    input  logic       arst_n,
    input  logic       rx,
    output logic [7:0] rx_data,
    output logic       rx_valid,
    output logic       rx_running
);
    localparam int TW = $clog2(TICKS_PER_BIT);
    localparam int HALF = TICKS_PER_BIT / 2;
    localparam int TAIL = (HALF > 4) ? HALF - 4 : 0; // rest of stop bit, less sync lag

    typedef enum logic [2:0] {IDLE, START, DATA, STOP, STOP_TAIL} state_t;

    state_t        state;
    logic [1:0]    rx_sync;
    logic [TW-1:0] tick;
    logic [2:0]    bit_idx;
    logic [7:0]    shift;
    logic          rx_s;
    logic          bit_mid;

    assign rx_s = rx_sync[1];
    assign bit_mid = (tick == TW'(TICKS_PER_BIT - 1));
    assign rx_running = (state != IDLE);
    assign rx_data = shift; // stable until the next start bit

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            rx_sync <= 2'b11; // line idles high
            state <= IDLE;
            tick <= '0;
            bit_idx <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_sync <= {rx_sync[0], rx};
            rx_valid <= 1'b0;
            tick <= tick + 1'b1;
            case (state)
                IDLE: begin
                    tick <= '0;
                    if (!rx_s) state <= START; // falling edge of start bit
                end
                START: begin
                    if (tick == TW'(HALF - 1)) begin
                        tick <= '0;
                        bit_idx <= '0;
                        state <= rx_s ? IDLE : DATA; // glitch, not a start bit
                    end
                end
                DATA: begin
                    if (bit_mid) begin
                        tick <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= STOP;
                    end
                end
                STOP: begin
                    if (bit_mid) begin
                        tick <= '0;
                        rx_valid <= rx_s; // bad stop bit drops the byte
                        state <= STOP_TAIL;
                    end
                end
                default: begin
                    if (tick >= TW'(TAIL)) state <= IDLE;
                end
            endcase
        end
    end

    // lsb first
    always_ff @(posedge clk_in) begin
        if (state == DATA && bit_mid) shift <= {rx_s, shift[7:1]};
    end

endmodule

/* include/led_matrix_defines.svh */
`ifndef LED_MATRIX_DEFINES_SVH
`define LED_MATRIX_DEFINES_SVH

// panel geometry, 64 wide on the board
`define PIXEL_WIDTH 8
`define PIXEL_HEIGHT 8
`define PIXEL_HALFHEIGHT (`PIXEL_HEIGHT / 2)
`define BYTES_PER_PIXEL 2

// serial line, clk_in cycles per bit
`define UART_TICKS_PER_BIT 65

// scan timing in clk_in cycles
`define PIXEL_CLK_HALF 2
`define FETCH_LATENCY 4
`define OE_UNIT 8 // lit time of plane 0

// host commands
`define CMD_FRAME 8'h46
`define CMD_RGB_ENABLE 8'h43
`define CMD_BRIGHTNESS 8'h42

`endif

/* verification/tb_led_matrix.sv */
`timescale 1ns/1ps
`include "led_matrix_defines.svh"

module tb_led_matrix;
    localparam int W = `PIXEL_WIDTH;
    localparam int HALF = `PIXEL_HALFHEIGHT;
    localparam int NPIX = `PIXEL_WIDTH * `PIXEL_HEIGHT;
    localparam int BIT_CYCLES = `UART_TICKS_PER_BIT;
    // one plane of shifting plus the latch cycle
    localparam int PLANE_SHIFT = W * (1 + `FETCH_LATENCY + 2 * `PIXEL_CLK_HALF) + 1;
    localparam int FRAME_CYCLES = HALF * (6 * PLANE_SHIFT + `OE_UNIT * 63);
    localparam int UART_BYTES = 2 * (NPIX * `BYTES_PER_PIXEL + 1) + 8;
    localparam int LIMIT_CYCLES = 2 * (UART_BYTES * 11 * BIT_CYCLES + 2 * FRAME_CYCLES);

    logic                        clk_in = 1'b0;
    logic                        arst_n;
    logic                        uart_rx;
    logic                        rx_running;
    led_matrix_pkg::rgb_bits_t   rgb1;
    led_matrix_pkg::rgb_bits_t   rgb2;
    led_matrix_pkg::row_addr_t   row_address_active;
    logic                        clk_pixel;
    logic                        row_latch;
    logic                        output_enable_n;

    logic [15:0]                 model [NPIX]; // frame as the host sent it
    led_matrix_pkg::rgb_bits_t   model_rgb_en;
    led_matrix_pkg::plane_mask_t model_bright_en;
    logic                        armed; // compare columns only when set
    string                       test_name;
    int                          errors;
    int                          err_mark;
    int                          pass_count;
    int                          fail_count;
    logic [31:0]                 rng;
    event                        latch_ev;
    led_matrix_pkg::row_addr_t   last_active;

    // monitor state
    logic                        prev_clk;
    logic                        prev_latch;
    logic                        prev_oe;
    logic                        lit_done; // lit period seen since the last latch
    int                          col_idx;
    int                          oe_count;
    int                          cur_plane;
    int                          cur_row;
    int                          disp_plane;
    led_matrix_pkg::rgb_bits_t   col1 [W];
    led_matrix_pkg::rgb_bits_t   col2 [W];

    led_matrix_top i_led_matrix_top (
        .clk_in             (clk_in),
        .arst_n             (arst_n),
        .uart_rx            (uart_rx),
        .rx_running         (rx_running),
        .rgb1               (rgb1),
        .rgb2               (rgb2),
        .row_address_active (row_address_active),
        .clk_pixel          (clk_pixel),
        .row_latch          (row_latch),
        .output_enable_n    (output_enable_n)
    );

    always #20 clk_in = ~clk_in;

    function automatic led_matrix_pkg::rgb_bits_t expected_rgb(
        input logic [15:0]                 pixel,
        input int                          plane,
        input led_matrix_pkg::rgb_bits_t   rgb_en,
        input led_matrix_pkg::plane_mask_t bright_en
    );
        logic [5:0]                red6;
        logic [5:0]                green6;
        logic [5:0]                blue6;
        led_matrix_pkg::rgb_bits_t result;
        red6 = {pixel[15:11], pixel[15]}; // msb repeated as new lsb
        green6 = pixel[10:5];
        blue6 = {pixel[4:0], pixel[4]};
        result[0] = red6[plane] & rgb_en[0] & bright_en[plane];
        result[1] = green6[plane] & rgb_en[1] & bright_en[plane];
        result[2] = blue6[plane] & rgb_en[2] & bright_en[plane];
        return result;
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // 8N1, lsb first, one idle cycle before the start bit
    task automatic send_byte(input logic [7:0] data);
        logic [9:0] frame_bits;
        frame_bits = {1'b1, data, 1'b0};
        @(posedge clk_in);
        #2;
        for (int i = 0; i < 10; i++) begin
            uart_rx = frame_bits[i];
            repeat (BIT_CYCLES) @(posedge clk_in);
            #2;
        end
    endtask

    task automatic send_frame();
        send_byte(`CMD_FRAME);
        for (int i = 0; i < NPIX; i++) begin
            send_byte(model[i][15:8]); // high byte first
            send_byte(model[i][7:0]);
        end
    endtask

    // every plane of every row once, starting at a clean latch
    task automatic scan_check();
        @(latch_ev);
        armed = 1'b1;
        repeat (6 * HALF) @(latch_ev);
        armed = 1'b0;
    endtask

    task automatic finish_test();
        if (errors == err_mark) begin
            pass_count++;
            $display("PASS %s", test_name);
        end else begin
            fail_count++;
            $display("FAIL %s with %0d errors", test_name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    task automatic check_latch();
        led_matrix_pkg::rgb_bits_t exp_top;
        led_matrix_pkg::rgb_bits_t exp_bot;
        last_active = row_address_active;
        assert (int'(row_address_active) == cur_row) else begin
            $display("ERROR %s: latched row expected %0d actual %0d",
                     test_name, cur_row, row_address_active);
            errors++;
        end
        assert (col_idx == W) else begin
            $display("ERROR %s: pixel clocks per plane expected %0d actual %0d",
                     test_name, W, col_idx);
            errors++;
        end
        assert (lit_done) else begin
            $display("ERROR %s: plane %0d was never lit before the next latch",
                     test_name, disp_plane);
            errors++;
        end
        lit_done = 1'b0;
        if (armed) begin
            for (int x = 0; x < W; x++) begin
                exp_top = expected_rgb(model[cur_row * W + x], cur_plane,
                                       model_rgb_en, model_bright_en);
                exp_bot = expected_rgb(model[(cur_row + HALF) * W + x], cur_plane,
                                       model_rgb_en, model_bright_en);
                assert (col1[x] == exp_top) else begin
                    $display("ERROR %s: row %0d plane %0d col %0d top expected %b actual %b",
                             test_name, cur_row, cur_plane, x, exp_top, col1[x]);
                    errors++;
                end
                assert (col2[x] == exp_bot) else begin
                    $display("ERROR %s: row %0d plane %0d col %0d bottom expected %b actual %b",
                             test_name, cur_row, cur_plane, x, exp_bot, col2[x]);
                    errors++;
                end
            end
        end
        disp_plane = cur_plane;
        col_idx = 0;
        if (cur_plane == 5) begin
            cur_plane = 0;
            cur_row = (cur_row + 1) % HALF;
        end else begin
            cur_plane++;
        end
    endtask

    // panel side, sampled half a cycle away from the DUT's edges
    always @(negedge clk_in) begin
        if (!arst_n) begin
            prev_clk = 1'b0;
            prev_latch = 1'b0;
            prev_oe = 1'b1;
            lit_done = 1'b1; // nothing lit before the first latch
            col_idx = 0;
            oe_count = 0;
            cur_plane = 0;
            cur_row = 0;
            disp_plane = 0;
        end else begin
            if (clk_pixel && !prev_clk) begin
                if (col_idx < W) begin
                    col1[col_idx] = rgb1;
                    col2[col_idx] = rgb2;
                end
                col_idx++;
            end
            if (!output_enable_n) oe_count++;
            if (output_enable_n && !prev_oe) begin
                assert (oe_count == (`OE_UNIT << disp_plane)) else begin
                    $display("ERROR %s: lit cycles of plane %0d expected %0d actual %0d",
                             test_name, disp_plane, `OE_UNIT << disp_plane, oe_count);
                    errors++;
                end
                oe_count = 0;
                lit_done = 1'b1;
            end
            if (row_latch && !prev_latch) begin
                check_latch();
                ->latch_ev;
            end
            prev_clk = clk_pixel;
            prev_latch = row_latch;
            prev_oe = output_enable_n;
        end
    end

    initial begin
        #(LIMIT_CYCLES * 40);
        $display("timeout: the tests did not finish within %0d cycles", LIMIT_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        arst_n = 1'b0;
        uart_rx = 1'b1; // idle line
        armed = 1'b0;
        errors = 0;
        err_mark = 0;
        pass_count = 0;
        fail_count = 0;
        rng = 32'h6238_3703;
        model_rgb_en = 3'b111;
        model_bright_en = 6'h3f;

        test_name = "reset_state";
        repeat (10) @(posedge clk_in);
        // oe_n latch clk_pixel rx_running rgb1 rgb2
        assert ({output_enable_n, row_latch, clk_pixel, rx_running, rgb1, rgb2} ==
                10'b10_0000_0000) else begin
            $display("ERROR %s: reset outputs expected %b actual %b", test_name,
                     10'b10_0000_0000,
                     {output_enable_n, row_latch, clk_pixel, rx_running, rgb1, rgb2});
            errors++;
        end
        #2;
        arst_n = 1'b1;
        @(latch_ev);
        assert (last_active == '0) else begin
            $display("ERROR %s: first latched row expected 0 actual %0d", test_name, last_active);
            errors++;
        end
        finish_test();

        test_name = "frame_load";
        for (int i = 0; i < NPIX; i++) model[i] = 16'(i * 40503) ^ 16'h5a3c; // all distinct
        send_frame();
        scan_check();
        finish_test();

        test_name = "rgb_enable";
        send_byte(`CMD_RGB_ENABLE);
        send_byte(8'h02); // green only
        model_rgb_en = 3'b010;
        scan_check();
        send_byte(`CMD_RGB_ENABLE);
        send_byte(8'h07);
        model_rgb_en = 3'b111;
        finish_test();

        test_name = "brightness_enable";
        send_byte(`CMD_BRIGHTNESS);
        send_byte(8'h29); // planes 0, 3 and 5
        model_bright_en = 6'h29;
        scan_check();
        send_byte(`CMD_BRIGHTNESS);
        send_byte(8'h3f);
        model_bright_en = 6'h3f;
        finish_test();

        test_name = "display_time";
        repeat (6 * HALF + 1) @(latch_ev); // lit time and row order checked by the monitor
        finish_test();

        test_name = "random_frame";
        for (int i = 0; i < NPIX; i++) begin
            rng = xorshift32(rng);
            model[i] = rng[15:0];
        end
        send_frame();
        scan_check();
        finish_test();

        $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
